//--- list.f
+incdir+include
source/board_pkg.sv
source/csr_pkg.sv
source/reset_seq.sv
source/host_csr_bridge.sv
source/sysctl_gpio.sv
source/activity_led.sv
source/soc_ctrl_top.sv
test/tb_soc_ctrl.sv

//--- Bender.yml
package:
  name: soc_ctrl

sources:
  - source/board_pkg.sv
  - source/csr_pkg.sv
  - source/reset_seq.sv
  - source/host_csr_bridge.sv
  - source/sysctl_gpio.sv
  - source/activity_led.sv
  - source/soc_ctrl_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_soc_ctrl.sv

//--- include/tb_host_tasks.svh
/*
 * Host port tasks for the board control testbench
 * Four-phase req/ack accesses and cycle wait helper
 */
`ifndef TB_HOST_TASKS_SVH
`define TB_HOST_TASKS_SVH

// Returns 2 ns after the n-th rising edge
task automatic wait_cycles(input int n);
	repeat (n) @(posedge sys_clk);
	#2;
endtask

// Caller sits 2 ns after an edge, with ack already low
task automatic host_access(
	input  logic                  we,
	input  logic [CSR_ADDR_W-1:0] addr,
	input  logic [CSR_DATA_W-1:0] wdata,
	output logic [CSR_DATA_W-1:0] rdata
);
	int edges;
	host_req.addr.raw = addr;
	host_req.we       = we;
	host_req.wdata    = wdata;
	host_req_valid    = 1'b1;
	edges             = 0;
	// First edge samples valid, ack follows on the third
	while (!host_ack && edges < ACK_LIMIT) begin
		wait_cycles(1);
		edges++;
	end
	if (!host_ack) begin
		$display("ERROR: no ack from the bridge for address %h", addr);
		err_cnt++;
	end else begin
		check_value("ack_latency", 32'(edges), 32'd3);
	end
	rdata          = host_rdata;
	host_req_valid = 1'b0;
	edges          = 0;
	// Ack drops one edge after valid goes low
	while (host_ack && edges < ACK_LIMIT) begin
		wait_cycles(1);
		edges++;
	end
	if (host_ack) begin
		$display("ERROR: ack stuck high after the request was dropped");
		err_cnt++;
	end
endtask

task automatic host_write(input logic [CSR_ADDR_W-1:0] addr, input logic [CSR_DATA_W-1:0] data);
	logic [CSR_DATA_W-1:0] unused_rd;
	host_access(1'b1, addr, data, unused_rd);
endtask

task automatic host_read(input logic [CSR_ADDR_W-1:0] addr, output logic [CSR_DATA_W-1:0] data);
	host_access(1'b0, addr, '0, data);
endtask

`endif

//--- test/tb_soc_ctrl.sv
/*
 * Board control testbench
 * Table driven host accesses plus GPIO, interrupt, LED and reset checks
 */
`timescale 1ns/1ps

module tb_soc_ctrl;
	import board_pkg::*;
	import csr_pkg::*;

	localparam int TAB_LEN        = 8;
	localparam int ACK_LIMIT      = 16;
	localparam int TIMEOUT_CYCLES = TAB_LEN * 16 + 3 * DEBOUNCE_CYCLES + 4 * STRETCH_CYCLES;

	// One host access with its input setup
	typedef struct packed {
		logic                  we;
		logic [CSR_ADDR_W-1:0] addr;
		logic [CSR_DATA_W-1:0] wdata;
		logic [CSR_DATA_W-1:0] exp;
		logic [GPIO_IN_W-1:0]  gpio_in;
	} tab_entry_t;

	logic                  sys_clk;
	logic                  rst;
	logic                  board_reset_n;
	host_req_t             host_req;
	logic                  host_req_valid;
	logic                  host_ack;
	logic [CSR_DATA_W-1:0] host_rdata;
	logic [BTN_W-1:0]      btn;
	logic [DIPSW_W-1:0]    dipsw;
	logic                  uart_rxd;
	gpio_pins_t            gpio_pins;
	logic                  gpio_irq;
	logic                  rx_led;
	logic                  flash_reset_n;

	tab_entry_t            tab [TAB_LEN];
	int                    seed = 32'h9b7e;
	int                    err_cnt = 0;
	int                    check_cnt = 0;
	int                    cycle_cnt = 0;

	soc_ctrl_top soc_ctrl_top_inst (
		.sys_clk          (sys_clk),
		.rst_i            (rst),
		.board_reset_n_i  (board_reset_n),
		.host_req_i       (host_req),
		.host_req_valid_i (host_req_valid),
		.host_ack_o       (host_ack),
		.host_rdata_o     (host_rdata),
		.btn_i            (btn),
		.dipsw_i          (dipsw),
		.uart_rxd_i       (uart_rxd),
		.gpio_pins_o      (gpio_pins),
		.gpio_irq_o       (gpio_irq),
		.rx_led_o         (rx_led),
		.flash_reset_n_o  (flash_reset_n)
	);

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_cnt++;
		if (got !== exp) begin
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	// Bank above register
	function automatic logic [CSR_ADDR_W-1:0] make_addr(input logic [3:0] bank,
			input logic [9:0] regnum);
		return {bank, regnum};
	endfunction

	// LEDs 1:0, button LEDs 6:2, then e, rs, rw, data
	task automatic compare_pins(input logic [GPIO_OUT_W-1:0] exp);
		check_value("gpio_pins_o.led", 32'(gpio_pins.led), 32'(exp[1:0]));
		check_value("gpio_pins_o.btnled", 32'(gpio_pins.btnled), 32'(exp[6:2]));
		check_value("gpio_pins_o.lcd.e", 32'(gpio_pins.lcd.e), 32'(exp[7]));
		check_value("gpio_pins_o.lcd.rs", 32'(gpio_pins.lcd.rs), 32'(exp[8]));
		check_value("gpio_pins_o.lcd.rw", 32'(gpio_pins.lcd.rw), 32'(exp[9]));
		check_value("gpio_pins_o.lcd.data", 32'(gpio_pins.lcd.data), 32'(exp[13:10]));
	endtask

	`include "tb_host_tasks.svh"

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	// ------------------------------
	// Run limit
	// ------------------------------
	always @(posedge sys_clk) begin
		cycle_cnt++;
		if (cycle_cnt > TIMEOUT_CYCLES) begin
			$display("Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Checks: %0d  Errors: %0d", check_cnt, err_cnt + 1);
			$display("Test failures found");
			$finish;
		end
	end

	initial begin
		logic [CSR_DATA_W-1:0] rd;
		logic [DIPSW_W-1:0]    sw;
		logic [BTN_W-1:0]      bt;
		logic [GPIO_IN_W-1:0]  in_a;
		logic [GPIO_IN_W-1:0]  in_b;

		rst            = 1'b1;
		board_reset_n  = 1'b1;
		host_req       = '0;
		host_req_valid = 1'b0;
		btn            = '0;
		dipsw          = '0;
		uart_rxd       = 1'b1;

		// Random switch and button words
		sw   = DIPSW_W'($random(seed));
		bt   = BTN_W'($random(seed));
		in_a = {sw, bt};
		sw   = DIPSW_W'($random(seed));
		bt   = BTN_W'($random(seed));
		in_b = {sw, bt};

		tab[0] = '{1'b0, make_addr(SYSCTL_BANK, REG_SYSTEM_ID), '0, SYSTEM_ID, '0};
		tab[1] = '{1'b0, make_addr(SYSCTL_BANK, REG_GPIO_OUT), '0, '0, '0};
		tab[2] = '{1'b0, make_addr(4'd2, REG_SYSTEM_ID), '0, '0, '0};
		tab[3] = '{1'b1, make_addr(SYSCTL_BANK, REG_GPIO_OUT), 32'hffff_a5c3, 32'h25c3, '0};
		tab[4] = '{1'b1, make_addr(SYSCTL_BANK, REG_GPIO_OUT), 32'h0000_1234, 32'h1234, '0};
		tab[5] = '{1'b0, make_addr(SYSCTL_BANK, REG_GPIO_IN), '0, 32'(in_a), in_a};
		tab[6] = '{1'b0, make_addr(SYSCTL_BANK, REG_GPIO_IN), '0, 32'(in_b), in_b};
		tab[7] = '{1'b1, make_addr(SYSCTL_BANK, REG_GPIO_OUT), 32'h5555_2aaa, 32'h2aaa, in_b};

		repeat (4) @(posedge sys_clk);
		#2;
		rst = 1'b0;
		// Peripheral reset counts down after power-on
		wait_cycles(DEBOUNCE_CYCLES + 8);
		compare_pins('0);

		// ------------------------------
		// Stimulus table
		// ------------------------------
		for (int i = 0; i < TAB_LEN; i++) begin
			{dipsw, btn} = tab[i].gpio_in;
			wait_cycles(3);
			if (tab[i].we) begin
				host_write(tab[i].addr, tab[i].wdata);
				host_read(tab[i].addr, rd);
				check_value("host_rdata_o", rd, tab[i].exp);
				compare_pins(tab[i].exp[GPIO_OUT_W-1:0]);
			end else begin
				host_read(tab[i].addr, rd);
				check_value("host_rdata_o", rd, tab[i].exp);
			end
		end

		// Change interrupt set and clear
		host_write(make_addr(SYSCTL_BANK, REG_IRQ_PEND), '0);
		host_read(make_addr(SYSCTL_BANK, REG_IRQ_PEND), rd);
		check_value("irq_pend", rd, 32'd0);
		{dipsw, btn} = ~{dipsw, btn};
		wait_cycles(4);
		check_value("gpio_irq_o", gpio_irq, 32'd1);
		host_read(make_addr(SYSCTL_BANK, REG_IRQ_PEND), rd);
		check_value("irq_pend", rd, 32'd1);
		host_write(make_addr(SYSCTL_BANK, REG_IRQ_PEND), '0);
		check_value("gpio_irq_o", gpio_irq, 32'd0);
		host_read(make_addr(SYSCTL_BANK, REG_IRQ_PEND), rd);
		check_value("irq_pend", rd, 32'd0);

		// One cycle low pulse on the RX line
		uart_rxd = 1'b0;
		wait_cycles(1);
		uart_rxd = 1'b1;
		wait_cycles(1);
		check_value("rx_led_o", rx_led, 32'd1);
		wait_cycles(STRETCH_CYCLES - 5);
		check_value("rx_led_o", rx_led, 32'd1);
		wait_cycles(8);
		check_value("rx_led_o", rx_led, 32'd0);

		// ------------------------------
		// Reset paths
		// ------------------------------
		host_write(make_addr(SYSCTL_BANK, REG_GPIO_OUT), 32'h3fff);
		compare_pins(14'h3fff);
		host_write(make_addr(SYSCTL_BANK, REG_HARD_RESET), 32'h1);
		compare_pins('0);
		check_value("flash_reset_n_o", flash_reset_n, 32'd1);
		wait_cycles(DEBOUNCE_CYCLES + 8);
		host_read(make_addr(SYSCTL_BANK, REG_GPIO_OUT), rd);
		check_value("host_rdata_o", rd, 32'd0);

		// Board button held low
		board_reset_n = 1'b0;
		wait_cycles(8);
		check_value("flash_reset_n_o", flash_reset_n, 32'd0);
		board_reset_n = 1'b1;
		wait_cycles(FLASH_RST_CYCLES + 4);
		check_value("flash_reset_n_o", flash_reset_n, 32'd1);
		// Still inside the debounce hold
		host_read(make_addr(SYSCTL_BANK, REG_SYSTEM_ID), rd);
		check_value("host_rdata_o", rd, 32'd0);
		wait_cycles(DEBOUNCE_CYCLES);
		host_read(make_addr(SYSCTL_BANK, REG_SYSTEM_ID), rd);
		check_value("host_rdata_o", rd, SYSTEM_ID);

		$display("Checks: %0d  Errors: %0d", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- source/soc_ctrl_top.sv
/*
 * Board control top level
 * Reset sequencing, host CSR bridge, system controller and RX LED
 */
`timescale 1ns/1ps

module soc_ctrl_top (
	input  logic                           sys_clk,
	input  logic                           rst_i,
	input  logic                           board_reset_n_i,
	input  csr_pkg::host_req_t             host_req_i,
	input  logic                           host_req_valid_i,
	output logic                           host_ack_o,
	output logic [csr_pkg::CSR_DATA_W-1:0] host_rdata_o,
	input  logic [board_pkg::BTN_W-1:0]    btn_i,
	input  logic [board_pkg::DIPSW_W-1:0]  dipsw_i,
	input  logic                           uart_rxd_i,
	output board_pkg::gpio_pins_t          gpio_pins_o,
	output logic                           gpio_irq_o,
	output logic                           rx_led_o,
	output logic                           flash_reset_n_o
);
	import board_pkg::*;
	import csr_pkg::*;

	logic                  periph_rst;
	logic                  hard_reset;
	csr_req_t              csr_req;
	logic                  csr_strobe;
	logic [CSR_DATA_W-1:0] csr_rdata;
	logic [GPIO_IN_W-1:0]  gpio_in;

	// ------------------------------
	// Resets
	// ------------------------------
	reset_seq reset_seq_inst (
		.sys_clk         (sys_clk),
		.rst_i           (rst_i),
		.board_reset_n_i (board_reset_n_i),
		.hard_reset_i    (hard_reset),
		.periph_rst_o    (periph_rst),
		.flash_reset_n_o (flash_reset_n_o)
	);

	// Power-on reset only, survives peripheral reset
	host_csr_bridge host_csr_bridge_inst (
		.sys_clk          (sys_clk),
		.rst_i            (rst_i),
		.host_req_i       (host_req_i),
		.host_req_valid_i (host_req_valid_i),
		.host_ack_o       (host_ack_o),
		.host_rdata_o     (host_rdata_o),
		.csr_req_o        (csr_req),
		.csr_strobe_o     (csr_strobe),
		.csr_rdata_i      (csr_rdata)
	);

	// Switches above buttons
	assign gpio_in = {dipsw_i, btn_i};

	// Single CSR slave, read data goes straight back
	sysctl_gpio sysctl_gpio_inst (
		.sys_clk      (sys_clk),
		.periph_rst_i (periph_rst),
		.csr_req_i    (csr_req),
		.csr_strobe_i (csr_strobe),
		.csr_rdata_o  (csr_rdata),
		.gpio_in_i    (gpio_in),
		.gpio_pins_o  (gpio_pins_o),
		.gpio_irq_o   (gpio_irq_o),
		.hard_reset_o (hard_reset)
	);

	// UART RX activity
	activity_led rx_led_inst (
		.sys_clk (sys_clk),
		.rst_i   (rst_i),
		.line_i  (uart_rxd_i),
		.led_o   (rx_led_o)
	);

endmodule

//--- source/activity_led.sv
/*
 * Activity LED stretcher
 * Keeps the LED lit long enough to see short low pulses on a line
 */
`timescale 1ns/1ps

module activity_led (
	input  logic sys_clk,
	input  logic rst_i,
	input  logic line_i,
	output logic led_o
);
	import board_pkg::*;

	typedef logic [$clog2(STRETCH_CYCLES+1)-1:0] stretch_cnt_t;

	stretch_cnt_t stretch_cnt;

	always_ff @(posedge sys_clk) begin
		if (rst_i) begin
			stretch_cnt <= '0;
			led_o       <= 1'b0;
		end else begin
			// Low line means traffic, reload
			if (!line_i)
				stretch_cnt <= stretch_cnt_t'(STRETCH_CYCLES);
			else if (stretch_cnt != '0)
				stretch_cnt <= stretch_cnt - 1'b1;
			led_o <= (stretch_cnt != '0);
		end
	end

endmodule

//--- source/sysctl_gpio.sv
/*
 * System controller
 * GPIO in/out registers, change interrupt, system ID and hard reset,
 * with the output word mapped onto the board pins
 */
`timescale 1ns/1ps

module sysctl_gpio (
	input  logic                            sys_clk,
	input  logic                            periph_rst_i,
	input  csr_pkg::csr_req_t               csr_req_i,
	input  logic                            csr_strobe_i,
	output logic [csr_pkg::CSR_DATA_W-1:0]  csr_rdata_o,
	input  logic [board_pkg::GPIO_IN_W-1:0] gpio_in_i,
	output board_pkg::gpio_pins_t           gpio_pins_o,
	output logic                            gpio_irq_o,
	output logic                            hard_reset_o
);
	import board_pkg::*;
	import csr_pkg::*;

	logic [GPIO_IN_W-1:0]  gpio_meta;
	logic [GPIO_IN_W-1:0]  gpio_sync;
	logic [GPIO_IN_W-1:0]  gpio_prev;
	logic [GPIO_OUT_W-1:0] gpio_out;
	logic [CSR_REG_W-1:0]  reg_num;
	logic                  irq_pend;
	logic                  hard_reset_q;
	logic                  bank_sel;
	logic                  wr_en;
	logic                  gpio_change;

	// Address decode
	assign reg_num  = csr_req_i.addr.f.regnum;
	assign bank_sel = csr_strobe_i && (csr_req_i.addr.f.bank == SYSCTL_BANK);
	assign wr_en    = bank_sel && csr_req_i.we;

	// ------------------------------
	// GPIO inputs
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		gpio_meta <= gpio_in_i;
		gpio_sync <= gpio_meta;
		// Previous sample for edge detect
		gpio_prev <= gpio_sync;
	end

	assign gpio_change = (gpio_sync != gpio_prev);

	// Writable state
	always_ff @(posedge sys_clk) begin
		if (periph_rst_i) begin
			gpio_out     <= '0;
			irq_pend     <= 1'b0;
			hard_reset_q <= 1'b0;
		end else begin
			// One cycle pulse per write
			hard_reset_q <= wr_en && (reg_num == REG_HARD_RESET);
			if (wr_en && reg_num == REG_GPIO_OUT)
				gpio_out <= csr_req_i.wdata[GPIO_OUT_W-1:0];
			// New change beats a clear in the same cycle
			if (gpio_change)
				irq_pend <= 1'b1;
			else if (wr_en && reg_num == REG_IRQ_PEND)
				irq_pend <= 1'b0;
		end
	end

	// ------------------------------
	// Read data, one cycle after strobe
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (periph_rst_i) begin
			csr_rdata_o <= '0;
		end else begin
			csr_rdata_o <= '0;
			if (bank_sel) begin
				case (reg_num)
					REG_GPIO_IN:   csr_rdata_o <= CSR_DATA_W'(gpio_sync);
					REG_GPIO_OUT:  csr_rdata_o <= CSR_DATA_W'(gpio_out);
					REG_IRQ_PEND:  csr_rdata_o <= CSR_DATA_W'(irq_pend);
					REG_SYSTEM_ID: csr_rdata_o <= SYSTEM_ID;
					// Hard reset reads as zero
					default:       csr_rdata_o <= '0;
				endcase
			end
		end
	end

	// LEDs, button LEDs, then LCD
	assign gpio_pins_o  = gpio_pins_t'(gpio_out);
	assign gpio_irq_o   = irq_pend;
	assign hard_reset_o = hard_reset_q;

endmodule

//--- source/host_csr_bridge.sv
/*
 * Host to CSR bridge
 * Turns a four-phase req/ack host access into one CSR bus strobe
 */
`timescale 1ns/1ps

module host_csr_bridge (
	input  logic                           sys_clk,
	input  logic                           rst_i,
	input  csr_pkg::host_req_t             host_req_i,
	input  logic                           host_req_valid_i,
	output logic                           host_ack_o,
	output logic [csr_pkg::CSR_DATA_W-1:0] host_rdata_o,
	output csr_pkg::csr_req_t              csr_req_o,
	output logic                           csr_strobe_o,
	input  logic [csr_pkg::CSR_DATA_W-1:0] csr_rdata_i
);
	import csr_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_ACK
	} state_t;

	state_t   state;
	csr_req_t req_q;

	// ------------------------------
	// Handshake FSM
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (rst_i) begin
			state      <= ST_IDLE;
			host_ack_o <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (host_req_valid_i)
						state <= ST_ISSUE;
				end
				// Strobe is out for this one cycle
				ST_ISSUE: begin
					state <= ST_ACK;
				end
				ST_ACK: begin
					// First edge here lands the slave data
					if (!host_ack_o) begin
						host_ack_o <= 1'b1;
					end else if (!host_req_valid_i) begin
						host_ack_o <= 1'b0;
						state      <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Request and read data capture
	always_ff @(posedge sys_clk) begin
		if (state == ST_IDLE && host_req_valid_i) begin
			req_q.addr  <= host_req_i.addr;
			req_q.we    <= host_req_i.we;
			req_q.wdata <= host_req_i.wdata;
		end
		// Held until the next access, writes included
		if (state == ST_ACK && !host_ack_o)
			host_rdata_o <= csr_rdata_i;
	end

	assign csr_req_o    = req_q;
	assign csr_strobe_o = (state == ST_ISSUE);

endmodule

//--- source/reset_seq.sv
/*
 * Reset sequencer
 * Debounces the board reset button, handles hard reset requests and
 * releases the flash/codec reset ahead of the peripheral reset
 */
`timescale 1ns/1ps

module reset_seq (
	input  logic sys_clk,
	input  logic rst_i,
	input  logic board_reset_n_i,
	input  logic hard_reset_i,
	output logic periph_rst_o,
	output logic flash_reset_n_o
);
	import board_pkg::*;

	typedef logic [$clog2(DEBOUNCE_CYCLES+1)-1:0] debounce_cnt_t;
	typedef logic [$clog2(FLASH_RST_CYCLES+1)-1:0] flash_cnt_t;

	logic          btn_meta;
	logic          btn_sync;
	logic          restart;
	debounce_cnt_t debounce_cnt;
	flash_cnt_t    flash_cnt;

	// Button is active low, idle state is high
	always_ff @(posedge sys_clk) begin
		if (rst_i) begin
			btn_meta <= 1'b1;
			btn_sync <= 1'b1;
		end else begin
			btn_meta <= board_reset_n_i;
			btn_sync <= btn_meta;
		end
	end

	// ------------------------------
	// Peripheral reset debounce
	// ------------------------------
	assign restart = rst_i || !btn_sync || hard_reset_i;

	// Any activity reloads the full hold time
	always_ff @(posedge sys_clk) begin
		if (restart)
			debounce_cnt <= debounce_cnt_t'(DEBOUNCE_CYCLES);
		else if (debounce_cnt != '0)
			debounce_cnt <= debounce_cnt - 1'b1;
	end

	assign periph_rst_o = (debounce_cnt != '0);

	// Flash reset, hard reset leaves it alone
	always_ff @(posedge sys_clk) begin
		if (rst_i || !btn_sync)
			flash_cnt <= '0;
		else if (flash_cnt != flash_cnt_t'(FLASH_RST_CYCLES))
			flash_cnt <= flash_cnt + 1'b1;
	end

	// Released once the counter saturates
	assign flash_reset_n_o = (flash_cnt == flash_cnt_t'(FLASH_RST_CYCLES));

endmodule

//--- source/csr_pkg.sv
/*
 * CSR bus package
 * Address layout, bus and host request structs, sysctl register map
 */
package csr_pkg;

	localparam int CSR_ADDR_W = 14;
	localparam int CSR_BANK_W = 4;
	localparam int CSR_REG_W  = 10;
	localparam int CSR_DATA_W = 32;

	// Bank in the upper nibble
	typedef struct packed {
		logic [CSR_BANK_W-1:0] bank;
		logic [CSR_REG_W-1:0]  regnum;
	} csr_addr_fields_t;

	// Raw view for the bridge, decoded view for slaves
	typedef union packed {
		logic [CSR_ADDR_W-1:0] raw;
		csr_addr_fields_t      f;
	} csr_addr_u;

	// Bridge to slave
	typedef struct packed {
		csr_addr_u             addr;
		logic                  we;
		logic [CSR_DATA_W-1:0] wdata;
	} csr_req_t;

	// As presented on the host port
	typedef struct packed {
		csr_addr_u             addr;
		logic                  we;
		logic [CSR_DATA_W-1:0] wdata;
	} host_req_t;

	// ------------------------------
	// System controller map
	// ------------------------------
	localparam logic [CSR_BANK_W-1:0] SYSCTL_BANK    = 4'd1;
	localparam logic [CSR_REG_W-1:0]  REG_GPIO_IN    = 10'd0;
	localparam logic [CSR_REG_W-1:0]  REG_GPIO_OUT   = 10'd1;
	localparam logic [CSR_REG_W-1:0]  REG_IRQ_PEND   = 10'd2;
	localparam logic [CSR_REG_W-1:0]  REG_SYSTEM_ID  = 10'd3;
	localparam logic [CSR_REG_W-1:0]  REG_HARD_RESET = 10'd4;

	// "X401"
	localparam logic [CSR_DATA_W-1:0] SYSTEM_ID = 32'h58343031;

endpackage

//--- source/board_pkg.sv
/*
 * Board pin package
 * Pin counts, reset and LED timing, and the GPIO pin layout
 */
package board_pkg;

	// Front panel inputs
	localparam int BTN_W      = 5;
	localparam int DIPSW_W    = 8;

	// GPIO words, switches sit above buttons
	localparam int GPIO_IN_W  = 13;
	localparam int GPIO_OUT_W = 14;

	// ------------------------------
	// Timing, in sys_clk cycles
	// ------------------------------
	localparam int DEBOUNCE_CYCLES  = 1024;
	localparam int FLASH_RST_CYCLES = 128;
	localparam int STRETCH_CYCLES   = 256;

	// LCD pins, e lands in the lowest bit
	typedef struct packed {
		logic [3:0] data;
		logic       rw;
		logic       rs;
		logic       e;
	} lcd_pins_t;

	// Same bit order as the GPIO output register
	typedef struct packed {
		lcd_pins_t  lcd;
		logic [4:0] btnled;
		logic [1:0] led;
	} gpio_pins_t;

endpackage
